// ==== hdl/ahb_ui_pkg.sv ====
//////////////////////////////////////////////////
// AHB to memory UI bridge shared definitions
// Widths, vector types, UI command codes, model constants
//////////////////////////////////////////////////

package ahb_ui_pkg;

  // Bus widths
  localparam int ADDR_W  = 16;
  localparam int DATA_W  = 64;
  localparam int STRB_W  = DATA_W / 8;
  // Byte offset bits within one memory word
  localparam int BYTE_LG = $clog2(STRB_W);

  // Byte address, memory word, byte strobe or mask
  typedef logic [ADDR_W-1:0] ui_addr_t;
  typedef logic [DATA_W-1:0] ui_data_t;
  typedef logic [STRB_W-1:0] ui_strb_t;

  // UI command codes
  typedef logic [2:0] ui_cmd_t;
  localparam ui_cmd_t UI_CMD_WRITE = 3'd0;
  localparam ui_cmd_t UI_CMD_READ  = 3'd1;

  // Command FIFO entry: address, data, strobe, write flag
  localparam int CMD_W = ADDR_W + DATA_W + STRB_W + 1;

  // FIFO depths, kept small so back-pressure is reachable
  localparam int CMD_FIFO_DEPTH_LG = 2;
  localparam int RSP_FIFO_DEPTH_LG = 2;

  // Memory controller model
  localparam int MEM_WORDS_LG = 8;
  localparam int CALIB_CYCLES = 40;
  localparam int CALIB_CNT_W  = $clog2(CALIB_CYCLES);
  localparam int RD_LATENCY   = 4;

  typedef enum logic [1:0] {
    CALIB,
    IDLE,
    BUSY
  } mc_state_t;

endpackage

// ==== hdl/async_fifo.sv ====
//////////////////////////////////////////////////
// Dual-clock FIFO with Gray pointers and 2-flop syncs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module async_fifo #(
  parameter int WIDTH    = 8,
  parameter int DEPTH_LG = 2
) (
  // Write side
  input  logic             w_clk_i,
  input  logic             w_rst_n_i,
  input  logic [WIDTH-1:0] w_data_i,
  input  logic             w_push_i,
  output logic             w_full_o,
  // Read side
  input  logic             r_clk_i,
  input  logic             r_rst_n_i,
  input  logic             r_pop_i,
  output logic [WIDTH-1:0] r_data_o,
  output logic             r_valid_o
);

  // Entry storage
  logic [WIDTH-1:0] mem [2**DEPTH_LG];

  // Pointers carry one extra wrap bit
  logic [DEPTH_LG:0] w_bin, w_bin_next;
  logic [DEPTH_LG:0] w_gray, w_gray_next;
  logic [DEPTH_LG:0] r_bin, r_bin_next;
  logic [DEPTH_LG:0] r_gray, r_gray_next;

  // Synchronizer stages
  logic [DEPTH_LG:0] r_gray_w_q1, r_gray_w_q2;
  logic [DEPTH_LG:0] w_gray_r_q1, w_gray_r_q2;

  logic w_do_push;
  logic r_do_pop;
  logic w_full_next;
  logic r_empty_next;

  //////////////////////////////////////////////////
  // Write clock domain
  //////////////////////////////////////////////////

  assign w_do_push   = w_push_i & ~w_full_o;
  assign w_bin_next  = w_bin + {{DEPTH_LG{1'b0}}, w_do_push};
  assign w_gray_next = (w_bin_next >> 1) ^ w_bin_next;

  // Full when next write pointer laps the read pointer
  // with the top two Gray bits inverted and the rest equal
  assign w_full_next = (w_gray_next == {~r_gray_w_q2[DEPTH_LG:DEPTH_LG-1],
                                        r_gray_w_q2[DEPTH_LG-2:0]});

  always_ff @(posedge w_clk_i) begin
    if (w_do_push) begin
      mem[w_bin[DEPTH_LG-1:0]] <= w_data_i;
    end
  end

  always_ff @(posedge w_clk_i or negedge w_rst_n_i) begin
    if (!w_rst_n_i) begin
      w_bin    <= '0;
      w_gray   <= '0;
      w_full_o <= 1'b0;
    end else begin
      w_bin    <= w_bin_next;
      w_gray   <= w_gray_next;
      w_full_o <= w_full_next;
    end
  end

  // Read pointer into write domain
  always_ff @(posedge w_clk_i or negedge w_rst_n_i) begin
    if (!w_rst_n_i) begin
      r_gray_w_q1 <= '0;
      r_gray_w_q2 <= '0;
    end else begin
      r_gray_w_q1 <= r_gray;
      r_gray_w_q2 <= r_gray_w_q1;
    end
  end

  //////////////////////////////////////////////////
  // Read clock domain
  //////////////////////////////////////////////////

  assign r_do_pop    = r_pop_i & r_valid_o;
  assign r_bin_next  = r_bin + {{DEPTH_LG{1'b0}}, r_do_pop};
  assign r_gray_next = (r_bin_next >> 1) ^ r_bin_next;

  // Empty when pointers meet
  assign r_empty_next = (r_gray_next == w_gray_r_q2);

  // Show-ahead read port
  assign r_data_o = mem[r_bin[DEPTH_LG-1:0]];

  always_ff @(posedge r_clk_i or negedge r_rst_n_i) begin
    if (!r_rst_n_i) begin
      r_bin     <= '0;
      r_gray    <= '0;
      r_valid_o <= 1'b0;
    end else begin
      r_bin     <= r_bin_next;
      r_gray    <= r_gray_next;
      r_valid_o <= ~r_empty_next;
    end
  end

  // Write pointer into read domain
  always_ff @(posedge r_clk_i or negedge r_rst_n_i) begin
    if (!r_rst_n_i) begin
      w_gray_r_q1 <= '0;
      w_gray_r_q2 <= '0;
    end else begin
      w_gray_r_q1 <= w_gray;
      w_gray_r_q2 <= w_gray_r_q1;
    end
  end

endmodule

// ==== hdl/ahb_ui_converter.sv ====
//////////////////////////////////////////////////
// AHB-Lite subordinate to memory UI converter
// Commands cross to ui_clk, read data comes back
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_ui_converter import ahb_ui_pkg::*; (
  // AHB side
  input  logic     hclk_i,
  input  logic     rst_n_i,
  input  logic     hsel_i,
  input  ui_addr_t haddr_i,
  input  logic [1:0] htrans_i,
  input  logic     hwrite_i,
  input  ui_data_t hwdata_i,
  input  ui_strb_t hwstrb_i,
  input  logic     hready_i,
  output ui_data_t hrdata_o,
  output logic     hreadyout_o,
  // Memory UI side
  input  logic     ui_clk_i,
  input  logic     ui_rst_n_i,
  output ui_addr_t app_addr_o,
  output ui_cmd_t  app_cmd_o,
  output logic     app_en_o,
  input  logic     app_rdy_i,
  output logic     app_wdf_wren_o,
  output ui_data_t app_wdf_data_o,
  output ui_strb_t app_wdf_mask_o,
  output logic     app_wdf_end_o,
  input  logic     app_wdf_rdy_i,
  input  logic     init_calib_complete_i,
  input  ui_data_t app_rd_data_i,
  input  logic     app_rd_data_valid_i
);

  //////////////////////////////////////////////////
  // hclk domain
  //////////////////////////////////////////////////

  logic     start;
  logic     dp_active;
  logic     dp_write;
  ui_addr_t dp_addr;
  // Read command already queued for this data phase
  logic     rd_sent;
  logic     cmd_full;
  logic     cmd_push;
  logic     rsp_valid;
  logic     rsp_pop;

  // Selected, NONSEQ or SEQ, bus ready
  assign start = hsel_i & htrans_i[1] & hready_i;

  // Writes end once queued, reads once data is back
  assign hreadyout_o = ~dp_active | (dp_write ? ~cmd_full : rsp_valid);

  // Queue once per data phase, write data valid now
  assign cmd_push = dp_active & ~cmd_full & (dp_write | ~rd_sent);
  assign rsp_pop  = dp_active & ~dp_write & rsp_valid;

  always_ff @(posedge hclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dp_active <= 1'b0;
      dp_write  <= 1'b0;
      rd_sent   <= 1'b0;
    end else if (hready_i) begin
      // Address phase sampled, previous data phase done
      dp_active <= start;
      dp_write  <= hwrite_i;
      rd_sent   <= 1'b0;
    end else if (cmd_push) begin
      rd_sent   <= 1'b1;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (hready_i) begin
      dp_addr <= haddr_i;
    end
  end

  //////////////////////////////////////////////////
  // Clock crossing FIFOs
  //////////////////////////////////////////////////

  logic     cmd_valid;
  logic     cmd_pop;
  ui_addr_t q_addr;
  ui_data_t q_data;
  ui_strb_t q_strb;
  logic     q_write;

  async_fifo #(
    .WIDTH    (CMD_W),
    .DEPTH_LG (CMD_FIFO_DEPTH_LG)
  ) cmd_fifo (
    .w_clk_i   (hclk_i),
    .w_rst_n_i (rst_n_i),
    .w_data_i  ({dp_addr, hwdata_i, hwstrb_i, dp_write}),
    .w_push_i  (cmd_push),
    .w_full_o  (cmd_full),
    .r_clk_i   (ui_clk_i),
    .r_rst_n_i (ui_rst_n_i),
    .r_pop_i   (cmd_pop),
    .r_data_o  ({q_addr, q_data, q_strb, q_write}),
    .r_valid_o (cmd_valid)
  );

  // One read outstanding at most, so no overflow
  async_fifo #(
    .WIDTH    (DATA_W),
    .DEPTH_LG (RSP_FIFO_DEPTH_LG)
  ) rsp_fifo (
    .w_clk_i   (ui_clk_i),
    .w_rst_n_i (ui_rst_n_i),
    .w_data_i  (app_rd_data_i),
    .w_push_i  (app_rd_data_valid_i),
    .w_full_o  (),
    .r_clk_i   (hclk_i),
    .r_rst_n_i (rst_n_i),
    .r_pop_i   (rsp_pop),
    .r_data_o  (hrdata_o),
    .r_valid_o (rsp_valid)
  );

  //////////////////////////////////////////////////
  // ui_clk domain
  //////////////////////////////////////////////////

  logic ui_ready;
  logic app_take;

  assign ui_ready = app_rdy_i & app_wdf_rdy_i & init_calib_complete_i;
  // Presented command accepted by the controller
  assign app_take = app_en_o & app_rdy_i;
  // Load next entry into an empty or emptying slot
  assign cmd_pop  = cmd_valid & ui_ready & (~app_en_o | app_take);

  always_ff @(posedge ui_clk_i or negedge ui_rst_n_i) begin
    if (!ui_rst_n_i) begin
      app_en_o       <= 1'b0;
      app_wdf_wren_o <= 1'b0;
    end else if (cmd_pop) begin
      app_en_o       <= 1'b1;
      app_wdf_wren_o <= q_write;
    end else if (app_take) begin
      app_en_o       <= 1'b0;
      app_wdf_wren_o <= 1'b0;
    end
  end

  // Strobe to mask by inversion, 1 keeps the byte
  always_ff @(posedge ui_clk_i) begin
    if (cmd_pop) begin
      app_addr_o     <= q_addr;
      app_cmd_o      <= q_write ? UI_CMD_WRITE : UI_CMD_READ;
      app_wdf_data_o <= q_data;
      app_wdf_mask_o <= ~q_strb;
    end
  end

  // Single-beat writes, data ends with the command
  assign app_wdf_end_o = app_wdf_wren_o;

endmodule

// ==== hdl/ui_mem_ctrl.sv ====
//////////////////////////////////////////////////
// Memory controller UI model
// Calibration delay, ready throttle, masked array
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ui_mem_ctrl import ahb_ui_pkg::*; (
  input  logic     ui_clk_i,
  input  logic     rst_n_i,
  output logic     ui_rst_n_o,
  // Command port
  input  ui_addr_t app_addr_i,
  input  ui_cmd_t  app_cmd_i,
  input  logic     app_en_i,
  output logic     app_rdy_o,
  // Write data port
  input  logic     app_wdf_wren_i,
  input  ui_data_t app_wdf_data_i,
  input  ui_strb_t app_wdf_mask_i,
  input  logic     app_wdf_end_i,
  output logic     app_wdf_rdy_o,
  // Read data port
  output ui_data_t app_rd_data_o,
  output logic     app_rd_data_valid_o,
  output logic     init_calib_complete_o
);

  logic [1:0]             rst_sync;
  mc_state_t              state;
  logic [CALIB_CNT_W-1:0] calib_cnt;
  logic                   accept;
  logic                   wr_accept;
  logic                   rd_accept;
  logic [MEM_WORDS_LG-1:0] word_idx;

  ui_data_t               mem [2**MEM_WORDS_LG];
  ui_data_t               rd_pipe [RD_LATENCY];
  logic [RD_LATENCY-1:0]  rd_vld_pipe;

  // Reset synchronizer, async assert, sync release
  always_ff @(posedge ui_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end
  assign ui_rst_n_o = rst_sync[1];

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  assign app_rdy_o             = (state == IDLE);
  assign app_wdf_rdy_o         = (state != CALIB);
  assign init_calib_complete_o = (state != CALIB);

  assign accept    = app_en_i & app_rdy_o;
  // Write data arrives with its command
  assign wr_accept = accept & (app_cmd_i == UI_CMD_WRITE) & app_wdf_wren_i & app_wdf_end_i;
  assign rd_accept = accept & (app_cmd_i == UI_CMD_READ);

  // Byte address to word index
  assign word_idx = app_addr_i[BYTE_LG +: MEM_WORDS_LG];

  always_ff @(posedge ui_clk_i or negedge ui_rst_n_o) begin
    if (!ui_rst_n_o) begin
      state     <= CALIB;
      calib_cnt <= '0;
    end else begin
      case (state)
        CALIB: begin
          calib_cnt <= calib_cnt + 1'b1;
          if (calib_cnt == CALIB_CNT_W'(CALIB_CYCLES - 1)) begin
            state <= IDLE;
          end
        end
        IDLE: begin
          if (accept) begin
            state <= BUSY;
          end
        end
        // One dead cycle after every command
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Array and read pipeline
  //////////////////////////////////////////////////

  // Array comes up cleared, like FPGA block RAM
  initial begin
    for (int i = 0; i < 2**MEM_WORDS_LG; i++) begin
      mem[i] = '0;
    end
  end

  // Mask bit set keeps the old byte
  always_ff @(posedge ui_clk_i) begin
    if (wr_accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (!app_wdf_mask_i[b]) begin
          mem[word_idx][8*b +: 8] <= app_wdf_data_i[8*b +: 8];
        end
      end
    end
  end

  // Read data moves one stage per cycle
  always_ff @(posedge ui_clk_i) begin
    rd_pipe[0] <= mem[word_idx];
    for (int s = 1; s < RD_LATENCY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  always_ff @(posedge ui_clk_i or negedge ui_rst_n_o) begin
    if (!ui_rst_n_o) begin
      rd_vld_pipe <= '0;
    end else begin
      rd_vld_pipe <= {rd_vld_pipe[RD_LATENCY-2:0], rd_accept};
    end
  end

  assign app_rd_data_o       = rd_pipe[RD_LATENCY-1];
  assign app_rd_data_valid_o = rd_vld_pipe[RD_LATENCY-1];

endmodule

// ==== hdl/ahb_ui_top.sv ====
//////////////////////////////////////////////////
// AHB to memory UI subsystem top
// Converter plus memory controller model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_ui_top import ahb_ui_pkg::*; (
  input  logic       hclk_i,
  input  logic       ui_clk_i,
  input  logic       rst_n_i,
  // AHB-Lite subordinate port
  input  logic       hsel_i,
  input  ui_addr_t   haddr_i,
  input  logic [1:0] htrans_i,
  input  logic       hwrite_i,
  input  ui_data_t   hwdata_i,
  input  ui_strb_t   hwstrb_i,
  input  logic       hready_i,
  output ui_data_t   hrdata_o,
  output logic       hreadyout_o,
  // Memory calibration status
  output logic       init_calib_complete_o
);

  // UI clock domain reset from the model
  logic     ui_rst_n;

  // Command and write data
  ui_addr_t app_addr;
  ui_cmd_t  app_cmd;
  logic     app_en;
  logic     app_rdy;
  logic     app_wdf_wren;
  ui_data_t app_wdf_data;
  ui_strb_t app_wdf_mask;
  logic     app_wdf_end;
  logic     app_wdf_rdy;

  // Read return
  ui_data_t app_rd_data;
  logic     app_rd_data_valid;

  ahb_ui_converter u_converter (
    .hclk_i                (hclk_i),
    .rst_n_i               (rst_n_i),
    .hsel_i                (hsel_i),
    .haddr_i               (haddr_i),
    .htrans_i              (htrans_i),
    .hwrite_i              (hwrite_i),
    .hwdata_i              (hwdata_i),
    .hwstrb_i              (hwstrb_i),
    .hready_i              (hready_i),
    .hrdata_o              (hrdata_o),
    .hreadyout_o           (hreadyout_o),
    .ui_clk_i              (ui_clk_i),
    .ui_rst_n_i            (ui_rst_n),
    .app_addr_o            (app_addr),
    .app_cmd_o             (app_cmd),
    .app_en_o              (app_en),
    .app_rdy_i             (app_rdy),
    .app_wdf_wren_o        (app_wdf_wren),
    .app_wdf_data_o        (app_wdf_data),
    .app_wdf_mask_o        (app_wdf_mask),
    .app_wdf_end_o         (app_wdf_end),
    .app_wdf_rdy_i         (app_wdf_rdy),
    .init_calib_complete_i (init_calib_complete_o),
    .app_rd_data_i         (app_rd_data),
    .app_rd_data_valid_i   (app_rd_data_valid)
  );

  ui_mem_ctrl u_mem_ctrl (
    .ui_clk_i              (ui_clk_i),
    .rst_n_i               (rst_n_i),
    .ui_rst_n_o            (ui_rst_n),
    .app_addr_i            (app_addr),
    .app_cmd_i             (app_cmd),
    .app_en_i              (app_en),
    .app_rdy_o             (app_rdy),
    .app_wdf_wren_i        (app_wdf_wren),
    .app_wdf_data_i        (app_wdf_data),
    .app_wdf_mask_i        (app_wdf_mask),
    .app_wdf_end_i         (app_wdf_end),
    .app_wdf_rdy_o         (app_wdf_rdy),
    .app_rd_data_o         (app_rd_data),
    .app_rd_data_valid_o   (app_rd_data_valid),
    .init_calib_complete_o (init_calib_complete_o)
  );

endmodule

// ==== dv/tb_ahb_ui_top.sv ====
//////////////////////////////////////////////////
// Testbench for the AHB to memory UI subsystem
// Reference memory model with LFSR stimulus and checkers
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ahb_ui_top import ahb_ui_pkg::*; ();

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // Transfer counts per test
  localparam int N_FULL = 16;
  localparam int N_PART = 32;
  localparam int N_RUN  = 24;
  localparam int N_MIX  = 300;
  // Calibration read and closing read included
  localparam int TOTAL_XFERS = 2 + 2 * N_FULL + 2 * N_PART + 2 * N_RUN + N_MIX;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_XFERS;

  logic       hclk   = 1'b0;
  logic       ui_clk = 1'b0;
  logic       rst_n;
  logic       hsel;
  ui_addr_t   haddr;
  logic [1:0] htrans;
  logic       hwrite;
  ui_data_t   hwdata;
  ui_strb_t   hwstrb;
  logic       hready;
  ui_data_t   hrdata;
  logic       hreadyout;
  logic       calib_done;

  logic [31:0] lfsr_state = 32'h4bc780b9;

  // Reference word array that starts cleared like the model
  ui_data_t ref_mem [2**MEM_WORDS_LG];

  // Read results waiting for the compare process
  ui_data_t exp_q [$];
  ui_data_t act_q [$];
  string    name_q [$];
  // Strobes of writes not yet seen at the UI
  ui_strb_t wstrb_q [$];

  always #5 hclk = ~hclk;
  always #3.5 ui_clk = ~ui_clk;

  // Single subordinate so bus ready is its own ready
  assign hready = hreadyout;

  ahb_ui_top dut_i (
    .hclk_i                (hclk),
    .ui_clk_i              (ui_clk),
    .rst_n_i               (rst_n),
    .hsel_i                (hsel),
    .haddr_i               (haddr),
    .htrans_i              (htrans),
    .hwrite_i              (hwrite),
    .hwdata_i              (hwdata),
    .hwstrb_i              (hwstrb),
    .hready_i              (hready),
    .hrdata_o              (hrdata),
    .hreadyout_o           (hreadyout),
    .init_calib_complete_o (calib_done)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // Word index to byte address
  function automatic ui_addr_t word_addr(input logic [63:0] w);
    return ui_addr_t'((w % (2**MEM_WORDS_LG)) * STRB_W);
  endfunction

  // Writes merge strobed bytes and every access returns the stored word
  function automatic ui_data_t ref_model(input logic wr, input ui_addr_t addr,
                                         input ui_data_t data, input ui_strb_t strb);
    int idx;
    idx = (addr / STRB_W) % (2**MEM_WORDS_LG);
    if (wr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
          ref_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    return ref_mem[idx];
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_data(input string test, input ui_data_t exp, input ui_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch in %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic compare_strb(input string test, input ui_strb_t exp, input ui_strb_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch in %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // AHB driver entered right after a rising edge
  //////////////////////////////////////////////////

  task automatic ahb_xfer(input logic wr, input ui_addr_t addr, input ui_data_t data,
                          input ui_strb_t strb, output ui_data_t rdata);
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    haddr  <= addr;
    hwrite <= wr;
    @(posedge hclk);
    // Data phase
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwdata <= data;
    hwstrb <= strb;
    if (wr) begin
      wstrb_q.push_back(strb);
    end
    do begin
      @(negedge hclk);
    end while (!hreadyout);
    rdata = hrdata;
    @(posedge hclk);
  endtask

  task automatic ahb_write(input ui_addr_t addr, input ui_data_t data, input ui_strb_t strb);
    ui_data_t unused;
    ahb_xfer(1'b1, addr, data, strb, unused);
    void'(ref_model(1'b1, addr, data, strb));
  endtask

  task automatic ahb_read(input ui_addr_t addr, output ui_data_t data);
    ahb_xfer(1'b0, addr, '0, '0, data);
  endtask

  // Read and queue actual and expected for the compare process
  task automatic read_check(input string test, input ui_addr_t addr);
    ui_data_t act;
    ahb_read(addr, act);
    exp_q.push_back(ref_model(1'b0, addr, '0, '0));
    act_q.push_back(act);
    name_q.push_back($sformatf("%s addr %h", test, addr));
  endtask

  // Pipelined writes to consecutive words with a wait state count
  task automatic write_run(input int n, input int base, output int stalls);
    ui_data_t d [$];
    ui_strb_t s [$];
    int       i;
    logic     rdy;
    for (int k = 0; k < n; k++) begin
      d.push_back(rand_bits(DATA_W));
      s.push_back(ui_strb_t'(rand_bits(STRB_W)));
    end
    stalls = 0;
    i      = 0;
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    haddr  <= word_addr(base);
    hwrite <= 1'b1;
    while (i < n) begin
      @(negedge hclk);
      rdy = hreadyout;
      if (!rdy) begin
        stalls++;
      end
      @(posedge hclk);
      if (rdy) begin
        // Address phase i taken and its data phase starts
        hwdata <= d[i];
        hwstrb <= s[i];
        wstrb_q.push_back(s[i]);
        void'(ref_model(1'b1, word_addr(base + i), d[i], s[i]));
        i++;
        if (i < n) begin
          haddr <= word_addr(base + i);
        end else begin
          hsel   <= 1'b0;
          htrans <= HTRANS_IDLE;
        end
      end
    end
    do begin
      @(negedge hclk);
      if (!hreadyout) begin
        stalls++;
      end
    end while (!hreadyout);
    @(posedge hclk);
  endtask

  //////////////////////////////////////////////////
  // Checkers and watchdog
  //////////////////////////////////////////////////

  // Read data compare
  always @(negedge hclk) begin
    while (act_q.size() > 0) begin
      compare_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  // Mask at the UI is the inverted AHB strobe
  always @(negedge ui_clk) begin
    if (dut_i.app_en && dut_i.app_rdy && dut_i.app_wdf_wren) begin
      if (wstrb_q.size() == 0) begin
        fail_run("A write reached the memory model that was never issued on the bus");
      end else begin
        compare_strb("write mask", ~wstrb_q.pop_front(), dut_i.app_wdf_mask);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge hclk);
    fail_run($sformatf("Timeout, the bus hung for %0d hclk cycles", WATCHDOG_CYCLES));
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    ui_addr_t addr;
    ui_data_t data;
    int       stalls;
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    hwstrb = '0;
    for (int w = 0; w < 2**MEM_WORDS_LG; w++) begin
      ref_mem[w] = '0;
    end
    repeat (8) @(posedge hclk);
    rst_n <= 1'b1;
    @(posedge hclk);

    // Read stalls until calibration ends and the array starts cleared
    if (calib_done !== 1'b0) begin
      fail_run("Calibration was already complete right after reset");
    end
    read_check("calib_stall", word_addr(rand_bits(MEM_WORDS_LG)));
    if (calib_done !== 1'b1) begin
      fail_run("First read completed before calibration was complete");
    end

    // Full-word write and read back
    for (int n = 0; n < N_FULL; n++) begin
      addr = word_addr(rand_bits(MEM_WORDS_LG));
      ahb_write(addr, rand_bits(DATA_W), '1);
      read_check("full_word", addr);
    end

    // Random strobes merge bytes
    for (int n = 0; n < N_PART; n++) begin
      addr = word_addr(rand_bits(MEM_WORDS_LG));
      ahb_write(addr, rand_bits(DATA_W), ui_strb_t'(rand_bits(STRB_W)));
      read_check("partial_strobe", addr);
    end

    // Back-to-back writes overrun the 4-entry command FIFO
    write_run(N_RUN, 100, stalls);
    if (stalls == 0) begin
      fail_run("Command FIFO never filled, hreadyout stayed high during the write run");
    end
    for (int n = 0; n < N_RUN; n++) begin
      read_check("back_pressure", word_addr(100 + n));
    end

    // Random mix that often reuses the address for read after write
    addr = word_addr(0);
    for (int n = 0; n < N_MIX; n++) begin
      if (rand_bits(2) != 0) begin
        addr = word_addr(rand_bits(MEM_WORDS_LG));
      end
      if (rand_bits(1)) begin
        data = rand_bits(DATA_W);
        ahb_write(addr, data, ui_strb_t'(rand_bits(STRB_W)));
      end else begin
        read_check("random_mix", addr);
      end
    end
    // Closing read drains any write still in flight
    read_check("random_mix_end", addr);

    repeat (2) @(posedge hclk);
    if (wstrb_q.size() != 0) begin
      fail_run("Writes issued on the bus never reached the memory model");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
hdl/ahb_ui_pkg.sv
hdl/async_fifo.sv
hdl/ahb_ui_converter.sv
hdl/ui_mem_ctrl.sv
hdl/ahb_ui_top.sv
dv/tb_ahb_ui_top.sv

// ==== Bender.yml ====
package:
  name: ahb_ui_bridge

sources:
  - hdl/ahb_ui_pkg.sv
  - hdl/async_fifo.sv
  - hdl/ahb_ui_converter.sv
  - hdl/ui_mem_ctrl.sv
  - hdl/ahb_ui_top.sv
  - target: test
    files:
      - dv/tb_ahb_ui_top.sv
